/* Bender.yml */
package:
  name: rv64_core

sources:
  # Package first, interface before its users
  - verilog/rv_pkg.sv
  - verilog/rv_reg_if.sv
  - verilog/rv_decode.sv
  - verilog/rv_regfile.sv
  - verilog/rv_csr.sv
  - verilog/rv_core.sv
  - verilog/rv64_top.sv

  # Testbench and bound checker
  - target: simulation
    files:
      - dv/rv_bus_chk.sv
      - dv/tb_top.sv

/* dv/rv_bus_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_bus_chk (
    input logic                    clk,
    input logic                    reset,
    input logic [rv_pkg::XLEN-1:0] pc,
    input logic                    interrupt_ack,
    input logic                    bus_write_enable,
    input logic                    bus_read_enable,
    input rv_pkg::rv_state_e       state,       // From u_core
    input logic [rv_pkg::XLEN-1:0] mcause       // From u_csr
);
    import rv_pkg::*;

    int error_count = 0;   // Watched by tb_top

    // Bus strobes
    a_enables_exclusive: assert property (@(posedge clk) disable iff (!reset)
        !(bus_write_enable && bus_read_enable))
        else begin
            error_count++;
            $error("read and write enables high together");
        end

    a_write_pulse: assert property (@(posedge clk) disable iff (!reset)
        bus_write_enable |=> !bus_write_enable)
        else begin
            error_count++;
            $error("write enable longer than one cycle");
        end

    a_read_pulse: assert property (@(posedge clk) disable iff (!reset)
        bus_read_enable |=> !bus_read_enable)
        else begin
            error_count++;
            $error("read enable longer than one cycle");
        end

    // Interrupt acknowledge and redirect
    a_ack_pulse: assert property (@(posedge clk) disable iff (!reset)
        interrupt_ack |=> !interrupt_ack)
        else begin
            error_count++;
            $error("interrupt_ack longer than one cycle");
        end

    a_trap_entry: assert property (@(posedge clk) disable iff (!reset)
        interrupt_ack |=> (state == ST_FLUSH && mcause == CAUSE_MEXT))   // Flush, cause 11
        else begin
            error_count++;
            $error("trap entry without flush or external cause");
        end

    a_trap_redirect: assert property (@(posedge clk) disable iff (!reset)
        interrupt_ack |=> (pc == TRAP_BASE))
        else begin
            error_count++;
            $error("pc not at TRAP_BASE after interrupt_ack");
        end

    // Quiet bus on the first edge out of reset
    a_reset_quiet: assert property (@(posedge clk)
        $rose(reset) |-> (!bus_write_enable && !bus_read_enable && !interrupt_ack
                          && pc == RAM_BASE))
        else begin
            error_count++;
            $error("bus not idle after reset");
        end

endmodule

`default_nettype wire

/* dv/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;
    import rv_pkg::*;

    localparam int ROM_WORDS = 96;          // Main program plus handler at 0x100
    localparam int EXP_STORES = 5;          // Main program stores only
    localparam int MAX_CYCLES = 400;        // ~40 instructions, 3 cycles worst case, wide margin
    localparam logic [31:0] NOP = 32'h0000_0013;       // addi x0, x0, 0
    localparam logic [63:0] LOAD_ADDR = 64'h1_0040;
    localparam logic [63:0] LOAD_VALUE = 64'h0123_4567_89AB_CDEF;
    localparam logic [63:0] MARKER_ADDR = 64'h300;     // Handler store target
    localparam logic [63:0] MARKER_VALUE = 64'h0CAF_E123;

    logic clk;
    logic reset;
    logic [31:0] instruction;
    logic [XLEN-1:0] pc;
    logic heartbeat;
    logic [3:0] interrupt_vector;
    logic interrupt_ack;
    logic [XLEN-1:0] bus_address;
    logic [XLEN-1:0] bus_write_data;
    logic bus_write_enable;
    logic bus_read_enable;
    logic [XLEN-1:0] bus_read_data;

    logic [31:0] rom [0:ROM_WORDS-1];
    logic [63:0] exp_addr [0:EXP_STORES-1];
    logic [63:0] exp_data [0:EXP_STORES-1];
    logic [63:0] log_addr [$];   // Every store seen on the bus
    logic [63:0] log_data [$];
    int main_idx = 0;
    int marker_count = 0;
    int ack_count = 0;
    int cycles = 0;
    int irq_delay;
    integer seed = 32'h86e1_3921;
    logic hb_prev = 1'b0;
    logic hb_armed = 1'b0;

    rv64_top u_dut (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .pc               (pc),
        .heartbeat        (heartbeat),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data)
    );

    bind rv64_top rv_bus_chk u_bus_chk (
        .clk              (clk),
        .reset            (reset),
        .pc               (pc),
        .interrupt_ack    (interrupt_ack),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .state            (u_core.state),
        .mcause           (u_csr.mcause)
    );

    // Instruction assemblers
    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] ld_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, 3'b011, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sd_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // ROM lookup, anything outside runs as nop
    function automatic logic [31:0] fetch_word(input logic [63:0] addr);
        logic [63:0] idx;
        idx = (addr - RAM_BASE) >> 2;
        if (addr >= RAM_BASE && idx < ROM_WORDS) begin
            return rom[idx];
        end
        return NOP;
    endfunction

    function automatic logic [63:0] read_word(input logic [63:0] addr);
        if (addr == LOAD_ADDR) begin
            return LOAD_VALUE;
        end
        return addr ^ 64'hA5A5_5A5A_C3C3_3C3C;   // Unloaded words follow the address
    endfunction

    task automatic abort_run(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // Logged store against the marker or the next main program entry
    task automatic check_store(input logic [63:0] addr, input logic [63:0] data);
        if (addr == MARKER_ADDR) begin
            assert (data == MARKER_VALUE)
                else abort_run($sformatf("marker data %h", data));
            marker_count++;
            assert (marker_count <= ack_count) else abort_run("marker without interrupt");
        end else begin
            assert (main_idx < EXP_STORES)
                else abort_run($sformatf("extra store to %h", addr));
            assert (addr == exp_addr[main_idx])
                else abort_run($sformatf("store %0d address %h, expected %h",
                                         main_idx, addr, exp_addr[main_idx]));
            assert (data == exp_data[main_idx])
                else abort_run($sformatf("store %0d data %h, expected %h",
                                         main_idx, data, exp_data[main_idx]));
            main_idx++;
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = NOP;
        end
        rom[0] = lui_word(5, 20'h00010);            // x5 = 0x10000, data base
        rom[1] = lui_word(6, 20'h12345);
        rom[2] = addi_word(6, 6, 12'h678);
        rom[3] = lui_word(7, 20'hFEDCB);            // Sign extends to 64 bits
        rom[4] = sd_word(6, 5, 12'h008);
        rom[5] = addi_word(7, 7, 12'hFFF);          // -1, twice would show in next store
        rom[6] = sd_word(7, 5, 12'hFF8);            // Negative offset
        rom[7] = ld_word(8, 5, 12'h040);
        rom[8] = addi_word(8, 8, 12'h010);          // Uses load result right away
        rom[9] = sd_word(8, 5, 12'h010);
        rom[10] = jal_word(1, 21'd8);               // 0x28 to 0x30, link 0x2C
        rom[11] = sd_word(0, 5, 12'h018);           // Jumped over
        rom[12] = sd_word(1, 5, 12'h020);
        rom[13] = jal_word(0, 21'd8);               // 0x34 to 0x3C, no link
        rom[14] = sd_word(1, 5, 12'h028);           // Jumped over
        rom[15] = lui_word(0, 20'h55555);           // x0 must stay zero
        rom[16] = sd_word(0, 5, 12'h030);
        rom[17] = jal_word(0, 21'd0);               // Park
        // Handler at TRAP_BASE
        rom[64] = lui_word(28, 20'h0CAFE);
        rom[65] = addi_word(28, 28, 12'h123);
        rom[66] = sd_word(28, 0, 12'h300);
        rom[67] = NOP;
        rom[68] = NOP;
        rom[69] = MRET_WORD;
        // Expected stores from the ISA rules
        exp_addr[0] = 64'h1_0008;
        exp_data[0] = 64'h1234_5678;
        exp_addr[1] = 64'hFFF8;
        exp_data[1] = 64'hFFFF_FFFF_FEDC_AFFF;
        exp_addr[2] = 64'h1_0010;
        exp_data[2] = LOAD_VALUE + 64'h10;
        exp_addr[3] = 64'h1_0020;
        exp_data[3] = RAM_BASE + 64'h2C;             // jal address plus 4
        exp_addr[4] = 64'h1_0030;
        exp_data[4] = 64'h0;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Memory models, driven on the falling edge
    always @(negedge clk) begin
        instruction <= fetch_word(pc);   // Ready well before the next fetch edge
    end

    always @(negedge clk) begin
        if (bus_read_enable) begin
            bus_read_data <= read_word(bus_address);   // Held until the next read
        end
    end

    // Store log and compare
    always @(negedge clk) begin
        if (reset && bus_write_enable) begin
            log_addr.push_back(bus_address);
            log_data.push_back(bus_write_data);
            check_store(log_addr[log_addr.size()-1], log_data[log_data.size()-1]);
        end
    end

    always @(negedge clk) begin
        if (hb_armed) begin
            assert (heartbeat != hb_prev) else abort_run("heartbeat did not toggle");
        end
        hb_prev = heartbeat;
        assert (u_dut.u_bus_chk.error_count == 0) else abort_run("bus checker assertion failed");
    end

    always @(posedge clk) begin
        if (reset && interrupt_ack) begin
            ack_count <= ack_count + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: program did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    // Interrupt source
    initial begin
        @(posedge reset);
        irq_delay = 3 + ($unsigned($random(seed)) % 14);
        repeat (irq_delay) @(negedge clk);
        interrupt_vector <= EXT_IRQ_CODE;
        wait (ack_count == 1);
        repeat (5) @(negedge clk);   // Still requesting while the handler runs masked
        assert (ack_count == 1) else abort_run("interrupt taken while MIE was clear");
        interrupt_vector <= 4'd0;
        repeat (12) @(negedge clk);  // Past mret
        interrupt_vector <= EXT_IRQ_CODE;
        wait (ack_count == 2);
        @(negedge clk);
        interrupt_vector <= 4'd0;
    end

    initial begin
        reset = 1'b0;
        instruction = NOP;
        interrupt_vector = 4'd0;
        bus_read_data = '0;
        load_program();
        repeat (4) @(negedge clk);
        assert (pc == RAM_BASE) else abort_run($sformatf("pc %h in reset", pc));
        assert (!bus_write_enable && !bus_read_enable) else abort_run("enable high in reset");
        assert (!interrupt_ack && !heartbeat) else abort_run("ack or heartbeat high in reset");
        reset = 1'b1;
        @(posedge clk);
        hb_armed = 1'b1;
        wait (main_idx == EXP_STORES && marker_count == 2);
        repeat (4) @(negedge clk);
        if (ack_count == 2 && log_addr.size() == EXP_STORES + 2
            && log_data.size() == EXP_STORES + 2
            && u_dut.u_bus_chk.error_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abort_run($sformatf("%0d interrupts, %0d stores at end", ack_count, log_addr.size()));
        end
    end

endmodule

`default_nettype wire

/* verilog/rv64_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv64_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [31:0]             instruction,
    output logic [rv_pkg::XLEN-1:0] pc,
    output logic                    heartbeat,
    input  logic [3:0]              interrupt_vector,
    output logic                    interrupt_ack,
    output logic [rv_pkg::XLEN-1:0] bus_address,
    output logic [rv_pkg::XLEN-1:0] bus_write_data,
    output logic                    bus_write_enable,
    output logic                    bus_read_enable,
    input  logic [rv_pkg::XLEN-1:0] bus_read_data
);
    import rv_pkg::*;

    // Decoder outputs
    logic [31:0] ir;
    rv_op_e op;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [XLEN-1:0] imm;

    // Core to CSR
    logic trap_slot;
    logic mret_go;
    logic [XLEN-1:0] epc;
    logic trap_take;
    logic [XLEN-1:0] trap_vector;
    logic [XLEN-1:0] return_pc;

    rv_reg_if regs_if ();

    rv_core u_core (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .pc               (pc),
        .heartbeat        (heartbeat),
        .interrupt_ack    (interrupt_ack),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .ir               (ir),
        .op               (op),
        .rd               (rd),
        .rs1              (rs1),
        .rs2              (rs2),
        .imm              (imm),
        .trap_slot        (trap_slot),
        .epc              (epc),
        .mret_go          (mret_go),
        .trap_take        (trap_take),
        .trap_vector      (trap_vector),
        .return_pc        (return_pc),
        .regs             (regs_if.core)
    );

    rv_decode u_decode (
        .ir  (ir),
        .op  (op),
        .rd  (rd),
        .rs1 (rs1),
        .rs2 (rs2),
        .imm (imm)
    );

    rv_regfile u_regfile (
        .clk   (clk),
        .reset (reset),
        .regs  (regs_if.regfile)
    );

    rv_csr u_csr (
        .clk              (clk),
        .reset            (reset),
        .interrupt_vector (interrupt_vector),
        .trap_slot        (trap_slot),
        .mret_go          (mret_go),
        .epc              (epc),
        .trap_take        (trap_take),
        .trap_vector      (trap_vector),
        .return_pc        (return_pc)
    );

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [31:0]             instruction,
    output logic [rv_pkg::XLEN-1:0] pc,
    output logic                    heartbeat,
    output logic                    interrupt_ack,
    output logic [rv_pkg::XLEN-1:0] bus_address,
    output logic [rv_pkg::XLEN-1:0] bus_write_data,
    output logic                    bus_write_enable,
    output logic                    bus_read_enable,
    input  logic [rv_pkg::XLEN-1:0] bus_read_data,
    output logic [31:0]             ir,
    input  rv_pkg::rv_op_e          op,
    input  logic [4:0]              rd,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    input  logic [rv_pkg::XLEN-1:0] imm,
    output logic                    trap_slot,
    output logic [rv_pkg::XLEN-1:0] epc,
    output logic                    mret_go,
    input  logic                    trap_take,
    input  logic [rv_pkg::XLEN-1:0] trap_vector,
    input  logic [rv_pkg::XLEN-1:0] return_pc,
    rv_reg_if.core                  regs
);
    import rv_pkg::*;

    rv_state_e state;
    logic [XLEN-1:0] ir_pc;   // Address of the word in ir
    logic [4:0] ld_rd;        // ir moves on while the load waits
    logic retire;             // ir executes this cycle

    assign trap_slot = (state == ST_EXEC);
    assign retire = trap_slot && !trap_take;   // Preempted word is dropped
    assign epc = ir_pc;
    assign interrupt_ack = trap_take;          // Same cycle as the redirect
    assign mret_go = retire && (op == OP_MRET);

    assign regs.rs1_addr = rs1;
    assign regs.rs2_addr = rs2;

    // Register write port
    always_comb begin
        regs.rd_we = 1'b0;
        regs.rd_addr = rd;
        regs.rd_data = '0;
        if (state == ST_LD_WB) begin
            regs.rd_we = 1'b1;   // Load data returned
            regs.rd_addr = ld_rd;
            regs.rd_data = bus_read_data;
        end else if (retire) begin
            case (op)
                OP_LUI: begin
                    regs.rd_we = 1'b1;
                    regs.rd_data = imm;
                end
                OP_ADDI: begin
                    regs.rd_we = 1'b1;
                    regs.rd_data = regs.rs1_data + imm;
                end
                OP_JAL: begin
                    regs.rd_we = (rd != 5'd0);   // Plain jump when rd is x0
                    regs.rd_data = ir_pc + 64'd4;
                end
                default: ;
            endcase
        end
    end

    // Fetch stage, ir follows the instruction port every edge
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir <= IR_RESET;
            ir_pc <= RAM_BASE;
            heartbeat <= 1'b0;
        end else begin
            ir <= instruction;
            ir_pc <= pc;             // Word fetched from pc
            heartbeat <= ~heartbeat;
        end
    end

    // Load destination
    always_ff @(posedge clk) begin
        if (retire && (op == OP_LD)) begin
            ld_rd <= rd;
        end
    end

    // Execute FSM, pc and bus strobes
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= ST_EXEC;
            pc <= RAM_BASE;
            bus_address <= RAM_BASE;
            bus_write_data <= '0;
            bus_write_enable <= 1'b0;
            bus_read_enable <= 1'b0;
        end else begin
            pc <= pc + 64'd4;   // Default sequential fetch
            bus_write_enable <= 1'b0;   // Strobes last one cycle
            bus_read_enable <= 1'b0;
            case (state)
                ST_EXEC: begin
                    if (trap_take) begin
                        pc <= trap_vector;
                        state <= ST_FLUSH;
                    end else begin
                        case (op)
                            OP_JAL: begin
                                pc <= ir_pc + imm;
                                state <= ST_FLUSH;
                            end
                            OP_MRET: begin
                                pc <= return_pc;   // Back to preempted word
                                state <= ST_FLUSH;
                            end
                            OP_SD: begin
                                bus_address <= regs.rs1_data + imm;
                                bus_write_data <= regs.rs2_data;
                                bus_write_enable <= 1'b1;
                                pc <= pc;   // Refetch the next word after flush
                                state <= ST_FLUSH;
                            end
                            OP_LD: begin
                                bus_address <= regs.rs1_data + imm;
                                bus_read_enable <= 1'b1;
                                pc <= pc;   // Held until write back
                                state <= ST_LD_WAIT;
                            end
                            default: ;   // nop, lui, addi
                        endcase
                    end
                end
                ST_FLUSH: state <= ST_EXEC;   // Wrong-path ir dropped
                ST_LD_WAIT: begin
                    pc <= pc;   // Memory works on the read
                    state <= ST_LD_WB;
                end
                ST_LD_WB: state <= ST_EXEC;   // Next word fetched this cycle
                default: state <= ST_EXEC;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/rv_csr.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_csr (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [3:0]              interrupt_vector,
    input  logic                    trap_slot,     // Core can be preempted now
    input  logic                    mret_go,
    input  logic [rv_pkg::XLEN-1:0] epc,           // Address of preempted instruction
    output logic                    trap_take,
    output logic [rv_pkg::XLEN-1:0] trap_vector,
    output logic [rv_pkg::XLEN-1:0] return_pc
);
    import rv_pkg::*;

    // mstatus, only the two interrupt enable bits exist
    logic mstatus_mie;
    logic mstatus_mpie;

    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;   // Last trap cause, read by software tools only
    logic [XLEN-1:0] mtvec;

    // External interrupt taken when requested and enabled
    assign trap_take = trap_slot && (interrupt_vector == EXT_IRQ_CODE) && mstatus_mie;

    assign trap_vector = mtvec;
    assign return_pc = mepc;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus_mie <= 1'b1;    // Interrupts on out of reset
            mstatus_mpie <= 1'b0;
            mepc <= '0;
            mcause <= '0;
        end else if (trap_take) begin
            mepc <= epc;
            mcause <= CAUSE_MEXT;
            mstatus_mpie <= mstatus_mie;
            mstatus_mie <= 1'b0;    // Handler runs masked
        end else if (mret_go) begin
            mstatus_mie <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
        end
    end

    // Trap base, fixed since no CSR writes exist
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mtvec <= TRAP_BASE;
        end else begin
            mtvec <= mtvec;
        end
    end

endmodule

`default_nettype wire

/* verilog/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  logic [31:0]             ir,
    output rv_pkg::rv_op_e          op,
    output logic [4:0]              rd,
    output logic [4:0]              rs1,
    output logic [4:0]              rs2,
    output logic [rv_pkg::XLEN-1:0] imm
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [XLEN-1:0] imm_u;   // lui
    logic [XLEN-1:0] imm_i;   // addi, ld
    logic [XLEN-1:0] imm_s;   // sd
    logic [XLEN-1:0] imm_j;   // jal

    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];

    // Register fields sit at fixed positions in every format
    assign rd = ir[11:7];
    assign rs1 = ir[19:15];
    assign rs2 = ir[24:20];

    // Sign extended immediates
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};
    assign imm_i = {{52{ir[31]}}, ir[31:20]};
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_j = {{43{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};   // Bit 0 implied

    always_comb begin
        op = OP_NOP;   // Anything unmatched
        imm = '0;
        if (ir == MRET_WORD) begin
            op = OP_MRET;   // No immediate
        end else begin
            case (opcode)
                OPC_LUI: begin
                    op = OP_LUI;
                    imm = imm_u;
                end
                OPC_OP_IMM: if (funct3 == F3_ADDI) begin
                    op = OP_ADDI;
                    imm = imm_i;
                end
                OPC_LOAD: if (funct3 == F3_DOUBLE) begin
                    op = OP_LD;
                    imm = imm_i;
                end
                OPC_STORE: if (funct3 == F3_DOUBLE) begin
                    op = OP_SD;
                    imm = imm_s;
                end
                OPC_JAL: begin
                    op = OP_JAL;
                    imm = imm_j;
                end
                default: ;   // Left as no-op
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // Machine widths and memory map
    localparam int unsigned XLEN = 64;
    localparam logic [XLEN-1:0] RAM_BASE = 64'h0000_0000_8000_0000;   // Reset pc
    localparam logic [XLEN-1:0] TRAP_BASE = RAM_BASE + 64'h100;       // Reset mtvec

    // Interrupt request and trap cause
    localparam logic [3:0] EXT_IRQ_CODE = 4'd1;                        // interrupt_vector code
    localparam logic [XLEN-1:0] CAUSE_MEXT = 64'h8000_0000_0000_000B;  // Interrupt bit, cause 11

    // Fetch register reset word, illegal opcode so it runs as a no-op
    localparam logic [31:0] IR_RESET = 32'h0000_0001;

    // Major opcodes of the supported encodings
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_JAL = 7'b1101111;

    // funct3 selects
    localparam logic [2:0] F3_ADDI = 3'b000;
    localparam logic [2:0] F3_DOUBLE = 3'b011;   // ld and sd

    // mret is matched as a whole word
    localparam logic [31:0] MRET_WORD = 32'h3020_0073;

    // Decoded operation
    typedef enum logic [2:0] {
        OP_NOP,
        OP_LUI,
        OP_ADDI,
        OP_LD,
        OP_SD,
        OP_JAL,
        OP_MRET
    } rv_op_e;

    // Execute stage state
    typedef enum logic [1:0] {
        ST_EXEC,      // ir retires this cycle
        ST_FLUSH,     // ir discarded after redirect
        ST_LD_WAIT,   // Read strobe on the bus
        ST_LD_WB      // Read data into rd
    } rv_state_e;

endpackage

`default_nettype wire

/* verilog/rv_reg_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface rv_reg_if;
    import rv_pkg::*;

    // Two read ports
    logic [4:0] rs1_addr;
    logic [4:0] rs2_addr;
    logic [XLEN-1:0] rs1_data;   // Combinational from array
    logic [XLEN-1:0] rs2_data;

    // One write port, taken at the clock edge
    logic [4:0] rd_addr;
    logic [XLEN-1:0] rd_data;
    logic rd_we;

    modport core (
        output rs1_addr, rs2_addr, rd_addr, rd_data, rd_we,
        input  rs1_data, rs2_data
    );

    modport regfile (
        input  rs1_addr, rs2_addr, rd_addr, rd_data, rd_we,
        output rs1_data, rs2_data
    );

endinterface

`default_nettype wire

/* verilog/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic      clk,
    input  logic      reset,
    rv_reg_if.regfile regs
);
    import rv_pkg::*;

    logic [XLEN-1:0] x [0:31];   // x0 stays zero, never written

    // Asynchronous reads
    assign regs.rs1_data = x[regs.rs1_addr];
    assign regs.rs2_data = x[regs.rs2_addr];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                x[i] <= '0;
            end
        end else if (regs.rd_we && (regs.rd_addr != 5'd0)) begin
            x[regs.rd_addr] <= regs.rd_data;   // Visible to reads next cycle
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
verilog/rv_pkg.sv
verilog/rv_reg_if.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_csr.sv
verilog/rv_core.sv
verilog/rv64_top.sv
dv/rv_bus_chk.sv
dv/tb_top.sv
